// File: rtl/sparse_act_pkg.sv
`default_nettype none

package sparse_act_pkg;

    // ==================================================
    // Default sizes
    // ==================================================

    // One activation word
    parameter int DATA_WIDTH_DEF     = 8;
    // Lanes per block, also the flag word width
    parameter int BLOCK_DEPTH_DEF    = 16;
    // Activation buffer, 256 words
    parameter int ACT_ADDR_WIDTH_DEF = 8;
    // Flag and count buffers, 16 blocks
    parameter int BLK_ADDR_WIDTH_DEF = 4;

    // ==================================================
    // State encodings
    // ==================================================

    // Distributor FSM, gray ordered along the normal path
    typedef enum logic [1:0] {
        D_IDLE       = 2'b00,
        D_CHECK_DATA = 2'b01,
        D_PACK       = 2'b11,
        D_WAIT_GET   = 2'b10
    } dist_state_e;

    // Packer FSM
    typedef enum logic [1:0] {
        P_IDLE   = 2'b00,
        P_BYPASS = 2'b01,
        P_FILL   = 2'b10,
        P_DONE   = 2'b11
    } pack_state_e;

endpackage

`default_nettype wire

// File: rtl/act_buffer.sv
`default_nettype none
`timescale 1ns/10ps

module act_buffer #(
    parameter int WIDTH      = 8,
    parameter int ADDR_WIDTH = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // Load side
    input  wire logic                  wr_en,
    input  wire logic [WIDTH-1:0]      wr_dat,

    // Read side
    input  wire logic                  en_rd,
    input  wire logic [ADDR_WIDTH-1:0] addr_rd,
    output logic                       val,
    output logic      [WIDTH-1:0]      dat_rd
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    // ==================================================
    // Storage
    // ==================================================

    logic [WIDTH-1:0]      mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    // One extra bit so a completely full bank is counted
    logic [ADDR_WIDTH:0]   unread;

    // Write and registered read, no reset on the array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_dat;
        end
        // Data valid one cycle after en_rd
        if (en_rd) begin
            dat_rd <= mem[addr_rd];
        end
    end

    // ==================================================
    // Write pointer and unread count
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            unread <= '0;
        end else begin
            // Pointer wraps at the bank depth
            if (wr_en) begin
                wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
            end
            case ({wr_en, en_rd})
                2'b10:   unread <= unread + (ADDR_WIDTH + 1)'(1);
                2'b01:   unread <= unread - (ADDR_WIDTH + 1)'(1);
                default: unread <= unread;
            endcase
        end
    end

    // Something left to read
    assign val = (unread != '0);

    // Reader must never pull from an empty bank
    a_no_rd_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        en_rd |-> val
    ) else $error("act_buffer: read enable while bank is empty");

endmodule

`default_nettype wire

// File: rtl/act_packer.sv
`default_nettype none
`timescale 1ns/10ps

module act_packer #(
    parameter int  DATA_WIDTH  = sparse_act_pkg::DATA_WIDTH_DEF,
    parameter int  BLOCK_DEPTH = sparse_act_pkg::BLOCK_DEPTH_DEF,
    localparam int CNT_WIDTH   = $clog2(BLOCK_DEPTH) + 1,
    localparam int LANE_WIDTH  = $clog2(BLOCK_DEPTH)
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Block setup from the distributor
    input  wire logic                              start,
    input  wire logic [CNT_WIDTH-1:0]              cnt,
    input  wire logic [BLOCK_DEPTH-1:0]            flag,

    // Activation word stream
    input  wire logic                              act_val,
    output logic                                   req_dat,
    input  wire logic                              val_dat,
    input  wire logic [DATA_WIDTH-1:0]             dat,

    // Dense block out
    output logic      [DATA_WIDTH*BLOCK_DEPTH-1:0] blk,
    output logic                                   near_done
);

    sparse_act_pkg::pack_state_e state;

    // Words still to request, words still to land
    logic [CNT_WIDTH-1:0]   req_left;
    logic [CNT_WIDTH-1:0]   arr_left;
    // Working flag copy, bits cleared as lanes fill
    logic [BLOCK_DEPTH-1:0] work_flag;
    logic [LANE_WIDTH-1:0]  lane;
    logic                   lane_hit;
    logic                   last_arr;

    // ==================================================
    // Lane cursor
    // ==================================================

    // Lowest set bit wins, so scan from the top down
    always_comb begin
        lane     = '0;
        lane_hit = 1'b0;
        for (int i = BLOCK_DEPTH - 1; i >= 0; i--) begin
            if (work_flag[i]) begin
                lane     = LANE_WIDTH'(i);
                lane_hit = 1'b1;
            end
        end
    end

    // Requests run ahead of arrivals, one per cycle
    assign req_dat   = (state == sparse_act_pkg::P_FILL) && act_val && (req_left != '0);
    assign last_arr  = val_dat && (arr_left == CNT_WIDTH'(1));
    // Final block is being registered this cycle
    assign near_done = (state == sparse_act_pkg::P_BYPASS) ||
                       ((state == sparse_act_pkg::P_FILL) && last_arr);

    // ==================================================
    // Packer FSM and block register
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= sparse_act_pkg::P_IDLE;
            req_left  <= '0;
            arr_left  <= '0;
            work_flag <= '0;
            blk       <= '0;
        end else begin
            case (state)
                sparse_act_pkg::P_IDLE: begin
                    if (start) begin
                        work_flag <= flag;
                        req_left  <= cnt;
                        arr_left  <= cnt;
                        // Nothing to scatter
                        if ((cnt == '0) || (flag == '0)) begin
                            state <= sparse_act_pkg::P_BYPASS;
                        end else begin
                            // Empty lanes end up zero
                            blk   <= '0;
                            state <= sparse_act_pkg::P_FILL;
                        end
                    end
                end
                sparse_act_pkg::P_BYPASS: begin
                    blk   <= '0;
                    state <= sparse_act_pkg::P_DONE;
                end
                sparse_act_pkg::P_FILL: begin
                    if (req_dat) begin
                        req_left <= req_left - CNT_WIDTH'(1);
                    end
                    // Drop the word into the current lane
                    if (val_dat && lane_hit) begin
                        blk[lane*DATA_WIDTH +: DATA_WIDTH] <= dat;
                        work_flag[lane]                    <= 1'b0;
                    end
                    if (val_dat) begin
                        arr_left <= arr_left - CNT_WIDTH'(1);
                    end
                    if (last_arr) begin
                        state <= sparse_act_pkg::P_DONE;
                    end
                end
                // One settle cycle before the next start
                sparse_act_pkg::P_DONE: state <= sparse_act_pkg::P_IDLE;
                default:                state <= sparse_act_pkg::P_IDLE;
            endcase
        end
    end

    // Count word and flag bitmap must describe the same block
    a_cnt_matches_flag: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> (cnt == CNT_WIDTH'($countones(flag)))
    ) else $error("act_packer: count does not match flag popcount");

endmodule

`default_nettype wire

// File: rtl/act_distributor.sv
`default_nettype none
`timescale 1ns/10ps

module act_distributor #(
    parameter int  DATA_WIDTH     = sparse_act_pkg::DATA_WIDTH_DEF,
    parameter int  BLOCK_DEPTH    = sparse_act_pkg::BLOCK_DEPTH_DEF,
    parameter int  ACT_ADDR_WIDTH = sparse_act_pkg::ACT_ADDR_WIDTH_DEF,
    parameter int  BLK_ADDR_WIDTH = sparse_act_pkg::BLK_ADDR_WIDTH_DEF,
    localparam int CNT_WIDTH      = $clog2(BLOCK_DEPTH) + 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Controller and array side
    input  wire logic                              fetch,
    input  wire logic                              get_act,
    output logic                                   rdy_act,

    // Activation buffer
    input  wire logic                              act_val,
    output logic                                   act_en_rd,
    output logic      [ACT_ADDR_WIDTH-1:0]         act_addr_rd,
    input  wire logic [DATA_WIDTH-1:0]             act_dat_rd,

    // Flag buffer
    input  wire logic                              flg_val,
    output logic                                   flg_en_rd,
    output logic      [BLK_ADDR_WIDTH-1:0]         flg_addr_rd,
    input  wire logic [BLOCK_DEPTH-1:0]            flg_dat_rd,

    // Count buffer
    input  wire logic                              cnt_val,
    output logic                                   cnt_en_rd,
    output logic      [BLK_ADDR_WIDTH-1:0]         cnt_addr_rd,
    input  wire logic [CNT_WIDTH-1:0]              cnt_dat_rd,

    // Dense block and its flag
    output logic      [DATA_WIDTH*BLOCK_DEPTH-1:0] act_block,
    output logic      [BLOCK_DEPTH-1:0]            act_flag
);

    sparse_act_pkg::dist_state_e state;
    sparse_act_pkg::dist_state_e next_state;

    logic                      blk_rd;
    logic [BLK_ADDR_WIDTH-1:0] blk_addr;
    logic                      start;
    logic                      req_dat;
    logic                      val_dat;
    logic                      near_done;

    // ==================================================
    // Fetch FSM
    // ==================================================

    // All three banks hold the next block
    assign blk_rd = (state == sparse_act_pkg::D_CHECK_DATA) && act_val && flg_val && cnt_val;

    always_comb begin
        next_state = state;
        case (state)
            sparse_act_pkg::D_IDLE:
                if (fetch)
                    next_state = sparse_act_pkg::D_CHECK_DATA;
            sparse_act_pkg::D_CHECK_DATA:
                if (blk_rd)
                    next_state = sparse_act_pkg::D_PACK;
            sparse_act_pkg::D_PACK:
                if (near_done)
                    next_state = sparse_act_pkg::D_WAIT_GET;
            sparse_act_pkg::D_WAIT_GET:
                if (get_act && rdy_act)
                    next_state = sparse_act_pkg::D_IDLE;
            default:
                next_state = sparse_act_pkg::D_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= sparse_act_pkg::D_IDLE;
            rdy_act <= 1'b0;
        end else begin
            state   <= next_state;
            // Registered ready, tracks WAIT_GET exactly
            rdy_act <= (next_state == sparse_act_pkg::D_WAIT_GET);
        end
    end

    // ==================================================
    // Read addresses and strobes
    // ==================================================

    // Flag and count share one block pointer
    assign flg_en_rd   = blk_rd;
    assign cnt_en_rd   = blk_rd;
    assign flg_addr_rd = blk_addr;
    assign cnt_addr_rd = blk_addr;
    assign act_en_rd   = req_dat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_addr    <= '0;
            act_addr_rd <= '0;
            start       <= 1'b0;
            val_dat     <= 1'b0;
            act_flag    <= '0;
        end else begin
            if (blk_rd) begin
                blk_addr <= blk_addr + BLK_ADDR_WIDTH'(1);
            end
            // Advances per request, wraps at bank end
            if (req_dat) begin
                act_addr_rd <= act_addr_rd + ACT_ADDR_WIDTH'(1);
            end
            // Count and flag readable one cycle after blk_rd
            start   <= blk_rd;
            // Word lands a cycle after its request
            val_dat <= req_dat;
            if (start) begin
                act_flag <= flg_dat_rd;
            end
        end
    end

    // ==================================================
    // Packer
    // ==================================================

    act_packer #(
        .DATA_WIDTH  (DATA_WIDTH),
        .BLOCK_DEPTH (BLOCK_DEPTH)
    ) u_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .cnt       (cnt_dat_rd),
        .flag      (flg_dat_rd),
        .act_val   (act_val),
        .req_dat   (req_dat),
        .val_dat   (val_dat),
        .dat       (act_dat_rd),
        .blk       (act_block),
        .near_done (near_done)
    );

    // Packer stays quiet while the block is parked for the array
    a_quiet_in_wait_get: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == sparse_act_pkg::D_WAIT_GET) |-> !act_en_rd && !near_done
    ) else $error("act_distributor: packer active while block waits in WAIT_GET");

endmodule

`default_nettype wire

// File: rtl/sparse_act_top.sv
`default_nettype none
`timescale 1ns/10ps

module sparse_act_top #(
    parameter int  DATA_WIDTH     = sparse_act_pkg::DATA_WIDTH_DEF,
    parameter int  BLOCK_DEPTH    = sparse_act_pkg::BLOCK_DEPTH_DEF,
    parameter int  ACT_ADDR_WIDTH = sparse_act_pkg::ACT_ADDR_WIDTH_DEF,
    parameter int  BLK_ADDR_WIDTH = sparse_act_pkg::BLK_ADDR_WIDTH_DEF,
    localparam int CNT_WIDTH      = $clog2(BLOCK_DEPTH) + 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,

    // Buffer loading
    input  wire logic                              act_wr_en,
    input  wire logic [DATA_WIDTH-1:0]             act_wr_dat,
    input  wire logic                              flg_wr_en,
    input  wire logic [BLOCK_DEPTH-1:0]            flg_wr_dat,
    input  wire logic                              cnt_wr_en,
    input  wire logic [CNT_WIDTH-1:0]              cnt_wr_dat,

    // Controller and array
    input  wire logic                              fetch,
    input  wire logic                              get_act,
    output logic                                   rdy_act,
    output logic      [DATA_WIDTH*BLOCK_DEPTH-1:0] act_block,
    output logic      [BLOCK_DEPTH-1:0]            act_flag
);

    // ==================================================
    // Buffer to distributor wiring
    // ==================================================

    logic                      act_val;
    logic                      act_en_rd;
    logic [ACT_ADDR_WIDTH-1:0] act_addr_rd;
    logic [DATA_WIDTH-1:0]     act_dat_rd;

    logic                      flg_val;
    logic                      flg_en_rd;
    logic [BLK_ADDR_WIDTH-1:0] flg_addr_rd;
    logic [BLOCK_DEPTH-1:0]    flg_dat_rd;

    logic                      cnt_val;
    logic                      cnt_en_rd;
    logic [BLK_ADDR_WIDTH-1:0] cnt_addr_rd;
    logic [CNT_WIDTH-1:0]      cnt_dat_rd;

    // Nonzero activation words
    act_buffer #(.WIDTH(DATA_WIDTH), .ADDR_WIDTH(ACT_ADDR_WIDTH)) u_act_buf (
        .clk (clk), .rst_n (rst_n), .wr_en (act_wr_en), .wr_dat (act_wr_dat),
        .en_rd (act_en_rd), .addr_rd (act_addr_rd), .val (act_val), .dat_rd (act_dat_rd)
    );

    // Per-block flag bitmaps
    act_buffer #(.WIDTH(BLOCK_DEPTH), .ADDR_WIDTH(BLK_ADDR_WIDTH)) u_flg_buf (
        .clk (clk), .rst_n (rst_n), .wr_en (flg_wr_en), .wr_dat (flg_wr_dat),
        .en_rd (flg_en_rd), .addr_rd (flg_addr_rd), .val (flg_val), .dat_rd (flg_dat_rd)
    );

    // Per-block nonzero counts
    act_buffer #(.WIDTH(CNT_WIDTH), .ADDR_WIDTH(BLK_ADDR_WIDTH)) u_cnt_buf (
        .clk (clk), .rst_n (rst_n), .wr_en (cnt_wr_en), .wr_dat (cnt_wr_dat),
        .en_rd (cnt_en_rd), .addr_rd (cnt_addr_rd), .val (cnt_val), .dat_rd (cnt_dat_rd)
    );

    act_distributor #(
        .DATA_WIDTH     (DATA_WIDTH),
        .BLOCK_DEPTH    (BLOCK_DEPTH),
        .ACT_ADDR_WIDTH (ACT_ADDR_WIDTH),
        .BLK_ADDR_WIDTH (BLK_ADDR_WIDTH)
    ) u_dist (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .get_act     (get_act),
        .rdy_act     (rdy_act),
        .act_val     (act_val),
        .act_en_rd   (act_en_rd),
        .act_addr_rd (act_addr_rd),
        .act_dat_rd  (act_dat_rd),
        .flg_val     (flg_val),
        .flg_en_rd   (flg_en_rd),
        .flg_addr_rd (flg_addr_rd),
        .flg_dat_rd  (flg_dat_rd),
        .cnt_val     (cnt_val),
        .cnt_en_rd   (cnt_en_rd),
        .cnt_addr_rd (cnt_addr_rd),
        .cnt_dat_rd  (cnt_dat_rd),
        .act_block   (act_block),
        .act_flag    (act_flag)
    );

endmodule

`default_nettype wire

// File: tests/tb_sparse_act.sv
`default_nettype none
`timescale 1ns/10ps

module tb_sparse_act;

    localparam int DW         = sparse_act_pkg::DATA_WIDTH_DEF;
    localparam int BD         = sparse_act_pkg::BLOCK_DEPTH_DEF;
    localparam int CNT_W      = $clog2(BD) + 1;
    localparam int BLK_W      = DW * BD;
    // Cycles allowed for any single wait
    localparam int WAIT_LIMIT = 300;

    logic             clk;
    logic             rst_n;
    logic             act_wr_en;
    logic [DW-1:0]    act_wr_dat;
    logic             flg_wr_en;
    logic [BD-1:0]    flg_wr_dat;
    logic             cnt_wr_en;
    logic [CNT_W-1:0] cnt_wr_dat;
    logic             fetch;
    logic             get_act;
    logic             rdy_act;
    logic [BLK_W-1:0] act_block;
    logic [BD-1:0]    act_flag;

    // Reference model, loaded words and flags in load order
    logic [DW-1:0]    word_q [$];
    logic [BD-1:0]    flag_q [$];
    logic [31:0]      lfsr;
    int               err_count;
    int               check_count;
    int               timeout_count;

    sparse_act_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .act_wr_en  (act_wr_en),
        .act_wr_dat (act_wr_dat),
        .flg_wr_en  (flg_wr_en),
        .flg_wr_dat (flg_wr_dat),
        .cnt_wr_en  (cnt_wr_en),
        .cnt_wr_dat (cnt_wr_dat),
        .fetch      (fetch),
        .get_act    (get_act),
        .rdy_act    (rdy_act),
        .act_block  (act_block),
        .act_flag   (act_flag)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
    endtask

    // Random flag, never empty
    task automatic rand_flag(output logic [BD-1:0] flg);
        logic [31:0] r;
        rand_bits(BD, r);
        flg = r[BD-1:0];
        if (flg == '0) begin
            flg = BD'(1);
        end
    endtask

    task automatic check_val(input string what, input logic [BLK_W-1:0] got,
                             input logic [BLK_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d",
                 check_count, err_count, timeout_count);
        if ((err_count == 0) && (timeout_count == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // ==================================================
    // Stimulus
    // ==================================================

    // Flag word and its count into the two block buffers
    task automatic load_meta(input logic [BD-1:0] flg);
        @(posedge clk);
        flg_wr_en  <= 1'b1;
        flg_wr_dat <= flg;
        cnt_wr_en  <= 1'b1;
        cnt_wr_dat <= CNT_W'($countones(flg));
        flag_q.push_back(flg);
        @(posedge clk);
        flg_wr_en  <= 1'b0;
        cnt_wr_en  <= 1'b0;
    endtask

    // One random word per set flag bit, back to back
    task automatic load_words(input logic [BD-1:0] flg);
        logic [31:0] r;
        for (int i = 0; i < BD; i++) begin
            if (flg[i]) begin
                rand_bits(DW, r);
                @(posedge clk);
                act_wr_en  <= 1'b1;
                act_wr_dat <= r[DW-1:0];
                word_q.push_back(r[DW-1:0]);
            end
        end
        @(posedge clk);
        act_wr_en <= 1'b0;
    endtask

    task automatic pulse_fetch();
        @(posedge clk);
        fetch <= 1'b1;
        @(posedge clk);
        fetch <= 1'b0;
    endtask

    task automatic pulse_get();
        @(posedge clk);
        get_act <= 1'b1;
        @(posedge clk);
        get_act <= 1'b0;
    endtask

    task automatic wait_rdy(input string what);
        int n;
        @(negedge clk);
        n = 1;
        while (!rdy_act && (n < WAIT_LIMIT)) begin
            @(negedge clk);
            n++;
        end
        if (!rdy_act) begin
            timeout_count++;
            $display("Timeout in %s: rdy_act did not rise within %0d cycles",
                     what, WAIT_LIMIT);
        end
    endtask

    // Oldest words go to the lowest set lanes, zero elsewhere
    task automatic check_block(input string what);
        logic [BD-1:0]    flg;
        logic [BLK_W-1:0] exp_blk;
        exp_blk = '0;
        flg     = '0;
        if (flag_q.size() == 0) begin
            err_count++;
            $display("Model has no flag word left for %s", what);
        end else begin
            flg = flag_q.pop_front();
        end
        for (int i = 0; i < BD; i++) begin
            if (flg[i]) begin
                if (word_q.size() == 0) begin
                    err_count++;
                    $display("Model ran out of activation words in %s", what);
                end else begin
                    exp_blk[i*DW +: DW] = word_q.pop_front();
                end
            end
        end
        check_val({what, " act_block"}, act_block, exp_blk);
        check_val({what, " act_flag"}, BLK_W'(act_flag), BLK_W'(flg));
    endtask

    // Wait, compare, hold a while, then hand the block to the array
    task automatic finish_block(input string what, input int hold);
        wait_rdy(what);
        if (timeout_count == 0) begin
            check_block(what);
            repeat (hold) @(negedge clk);
            pulse_get();
            @(negedge clk);
            check_val({what, " rdy_act after get"}, BLK_W'(rdy_act), '0);
        end
    endtask

    task automatic run_block(input string what, input int hold);
        pulse_fetch();
        finish_block(what, hold);
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic test_reset();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val("reset rdy_act", BLK_W'(rdy_act), '0);
        check_val("reset act_block", act_block, '0);
        check_val("reset act_flag", BLK_W'(act_flag), '0);
    endtask

    task automatic test_dense();
        load_meta('1);
        load_words('1);
        run_block("dense", 0);
    endtask

    task automatic test_sparse();
        logic [BD-1:0] flg;
        logic [31:0]   r;
        for (int b = 0; b < 8; b++) begin
            rand_flag(flg);
            load_meta(flg);
            load_words(flg);
            // Random get delay of 0 to 7 cycles
            rand_bits(3, r);
            run_block($sformatf("sparse %0d", b), int'(r[2:0]));
        end
    endtask

    // Next block's words sit in the buffer so act_val is high
    task automatic test_bypass();
        logic [BD-1:0] flg;
        rand_flag(flg);
        load_meta('0);
        load_meta(flg);
        load_words(flg);
        run_block("bypass", 0);
        run_block("after bypass", 0);
    endtask

    task automatic test_starved();
        logic [BD-1:0] flg;
        rand_flag(flg);
        load_meta(flg);
        pulse_fetch();
        // Fixed observation window, no words yet
        repeat (40) begin
            @(negedge clk);
            check_val("rdy_act while starved", BLK_W'(rdy_act), '0);
        end
        load_words(flg);
        finish_block("starved", 0);
    endtask

    task automatic test_backpressure();
        logic [BD-1:0]    flg;
        logic [BD-1:0]    nxt;
        logic [BLK_W-1:0] held_blk;
        logic [BD-1:0]    held_flg;
        rand_flag(flg);
        load_meta(flg);
        load_words(flg);
        pulse_fetch();
        wait_rdy("back-pressure");
        if (timeout_count != 0) begin
            return;
        end
        check_block("back-pressure");
        held_blk = act_block;
        held_flg = act_flag;
        // Next block arrives while the array stalls
        rand_flag(nxt);
        load_meta(nxt);
        load_words(nxt);
        for (int k = 0; k < 6; k++) begin
            pulse_fetch();
            repeat (8) begin
                @(negedge clk);
                check_val("rdy_act held", BLK_W'(rdy_act), BLK_W'(1));
                check_val("act_block held", act_block, held_blk);
                check_val("act_flag held", BLK_W'(act_flag), BLK_W'(held_flg));
            end
        end
        pulse_get();
        @(negedge clk);
        check_val("rdy_act after stall", BLK_W'(rdy_act), '0);
        // Ignored fetches must leave no trace, longer than a full pack
        repeat (40) begin
            @(negedge clk);
            check_val("rdy_act idle", BLK_W'(rdy_act), '0);
        end
        run_block("after back-pressure", 0);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        rst_n         = 1'b0;
        act_wr_en     = 1'b0;
        act_wr_dat    = '0;
        flg_wr_en     = 1'b0;
        flg_wr_dat    = '0;
        cnt_wr_en     = 1'b0;
        cnt_wr_dat    = '0;
        fetch         = 1'b0;
        get_act       = 1'b0;
        lfsr          = 32'h26700153;
        err_count     = 0;
        check_count   = 0;
        timeout_count = 0;

        test_reset();
        test_dense();
        test_sparse();
        test_bypass();
        test_starved();
        test_backpressure();

        // Every loaded word went out
        check_val("model words left", BLK_W'(word_q.size()), '0);
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// File: sparse_act.f
rtl/sparse_act_pkg.sv
rtl/act_buffer.sv
rtl/act_packer.sv
rtl/act_distributor.sv
rtl/sparse_act_top.sv
tests/tb_sparse_act.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the sparse activation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_sparse_act -f sparse_act.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
